// ==== rename_core.f ====
+incdir+common
common/rename_pkg.sv
source/rename_ctrl.sv
source/map_table.sv
source/free_list.sv
rob/rob_pointers.sv
rob/rob_entries.sv
source/rename_core.sv
bench/rename_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rename core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f rename_core.f --top-module rename_core_tb \
    --Mdir obj_dir -o rename_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rename_core_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
    exit 0
fi
exit 1

// ==== bench/rename_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_core_tb;
    import rename_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int STIM_CYCLES  = 2000;
    localparam int MARGIN       = 64;    // end drain plus slack
    localparam int MAX_CYCLES   = 3000;  // hard stop

    logic      clock, reset;
    logic      dispatch_valid, complete_valid, flush;
    arch_idx_t dispatch_src1, dispatch_src2, dispatch_dest;
    rob_idx_t  complete_tag;
    logic      dispatch_ready, retire_valid, recovering;
    phys_idx_t renamed_src1, renamed_src2, renamed_dest, retire_phys;
    rob_idx_t  dispatch_tag;
    arch_idx_t retire_dest;

    ////////////////////
    // reference model
    ////////////////////

    phys_idx_t  model_map  [`ARCH_REGS];  // speculative mapping
    phys_idx_t  commit_map [`ARCH_REGS];  // mapping as of last retire
    phys_idx_t  free_q     [$];
    arch_idx_t  rob_dest_q [$];           // oldest at front
    phys_idx_t  rob_new_q  [$];
    phys_idx_t  rob_old_q  [$];
    logic       rob_done_q [$];
    rob_idx_t   model_head, model_tail;
    logic       model_walking;
    logic       exp_ready, exp_retire;    // decided before the edge
    rob_count_t flush_occ, dut_walk_len;

    integer seed = 32'h424c;
    int cycle_count, error_count, check_total;
    int dispatch_count, retire_count, flush_count, full_cycles;

    rename_core dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_phys(input string name, input phys_idx_t got, input phys_idx_t exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s got 0x%h expected 0x%h cycle %0d", name, got, exp, cycle_count);
        end
    endtask

    task automatic check_arch(input string name, input arch_idx_t got, input arch_idx_t exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s got 0x%h expected 0x%h cycle %0d", name, got, exp, cycle_count);
        end
    endtask

    task automatic check_tag(input string name, input rob_idx_t got, input rob_idx_t exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s got 0x%h expected 0x%h cycle %0d", name, got, exp, cycle_count);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s got 0x%h expected 0x%h cycle %0d", name, got, exp, cycle_count);
        end
    endtask

    task automatic check_len(input string name, input rob_count_t got, input rob_count_t exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s got 0x%h expected 0x%h cycle %0d", name, got, exp, cycle_count);
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    task automatic reset_model();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            model_map[i]  = phys_idx_t'(i);  // identity
            commit_map[i] = phys_idx_t'(i);
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            free_q.push_back(phys_idx_t'(`ARCH_REGS + i));  // spares 8..15 in order
        end
        model_head    = '0;
        model_tail    = '0;
        model_walking = 1'b0;
    endtask

    task automatic drive_inputs(input logic stim_on);
        logic [31:0] rnd;
        int open_idx [$];
        int pick;
        rnd = $random(seed);
        for (int i = 0; i < rob_done_q.size(); i++) begin
            if (!rob_done_q[i]) open_idx.push_back(i);  // in flight, not yet done
        end
        dispatch_valid <= stim_on && (rnd[1:0] != 2'd0);  // 3 in 4
        dispatch_src1  <= rnd[4:2];
        dispatch_src2  <= rnd[7:5];
        dispatch_dest  <= rnd[10:8];
        flush          <= stim_on && (rnd[16:11] == 6'd0);  // rare
        if (stim_on && open_idx.size() > 0 && rnd[20:17] < 4'd5) begin
            pick = int'(rnd[31:21]) % open_idx.size();
            complete_valid <= 1'b1;
            complete_tag   <= model_head + rob_idx_t'(open_idx[pick]);
        end else begin
            complete_valid <= 1'b0;
            complete_tag   <= '0;
        end
    endtask

    task automatic check_outputs();
        exp_ready  = !model_walking && !flush && rob_dest_q.size() < `ROB_DEPTH;
        exp_retire = !model_walking && !flush && rob_dest_q.size() > 0 && rob_done_q[0];
        if (!model_walking && rob_dest_q.size() == `ROB_DEPTH) full_cycles++;
        if (recovering) dut_walk_len = rob_count_t'(dut_walk_len + 1);
        check_bit("dispatch_ready", dispatch_ready, exp_ready);
        check_bit("recovering", recovering, model_walking);
        check_phys("renamed_src1", renamed_src1, model_map[dispatch_src1]);
        check_phys("renamed_src2", renamed_src2, model_map[dispatch_src2]);
        if (free_q.size() > 0) check_phys("renamed_dest", renamed_dest, free_q[0]);
        check_tag("dispatch_tag", dispatch_tag, model_tail);
        check_bit("retire_valid", retire_valid, exp_retire);
        if (exp_retire) begin
            check_arch("retire_dest", retire_dest, rob_dest_q[0]);
            check_phys("retire_phys", retire_phys, rob_old_q[0]);
        end
    endtask

    // what the coming edge does to the core
    task automatic update_model();
        int slot;
        phys_idx_t taken;
        if (model_walking) begin
            if (rob_dest_q.size() > 0) begin
                model_map[rob_dest_q[$]] = rob_old_q[$];  // undo youngest
                free_q.push_front(rob_new_q[$]);
                void'(rob_dest_q.pop_back());
                void'(rob_new_q.pop_back());
                void'(rob_old_q.pop_back());
                void'(rob_done_q.pop_back());
                model_tail = model_tail - 1'b1;
            end else begin
                model_walking = 1'b0;  // last walk cycle
                check_len("recovering cycles", dut_walk_len, rob_count_t'(flush_occ + 1));
                // table seen by the sources is back at the retired state
                check_phys("renamed_src1", renamed_src1, commit_map[dispatch_src1]);
                check_phys("renamed_src2", renamed_src2, commit_map[dispatch_src2]);
            end
        end else begin
            if (complete_valid) begin
                slot = int'(rob_idx_t'(complete_tag - model_head));
                rob_done_q[slot] = 1'b1;
            end
            if (flush) begin
                model_walking = 1'b1;
                flush_occ     = rob_count_t'(rob_dest_q.size());
                dut_walk_len  = '0;
                flush_count++;
            end else begin
                if (exp_ready && dispatch_valid) begin
                    taken = free_q.pop_front();
                    rob_dest_q.push_back(dispatch_dest);
                    rob_new_q.push_back(taken);
                    rob_old_q.push_back(model_map[dispatch_dest]);
                    rob_done_q.push_back(1'b0);
                    model_map[dispatch_dest] = taken;
                    model_tail = model_tail + 1'b1;
                    dispatch_count++;
                end
                if (exp_retire) begin
                    commit_map[rob_dest_q[0]] = rob_new_q[0];
                    free_q.push_back(rob_old_q[0]);  // old mapping freed
                    void'(rob_dest_q.pop_front());
                    void'(rob_new_q.pop_front());
                    void'(rob_old_q.pop_front());
                    void'(rob_done_q.pop_front());
                    model_head = model_head + 1'b1;
                    retire_count++;
                end
            end
        end
    endtask

    // entered just after a rising edge
    task automatic run_cycle(input logic stim_on);
        drive_inputs(stim_on);
        @(negedge clock);  // outputs settled
        check_outputs();
        update_model();
        @(posedge clock);
    endtask

    function automatic int cycle_limit();
        int lim;
        lim = RESET_CYCLES + STIM_CYCLES + 8 * flush_count + MARGIN;
        if (lim > MAX_CYCLES) lim = MAX_CYCLES;
        return lim;
    endfunction

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        dispatch_dest  = '0;
        complete_valid = 1'b0;
        complete_tag   = '0;
        flush          = 1'b0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        for (int n = 0; n < STIM_CYCLES; n++) begin
            run_cycle(1'b1);
        end
        while (model_walking) run_cycle(1'b0);  // let a late walk finish
        if (full_cycles == 0) begin
            error_count++;
            $display("the reorder buffer never filled, back-pressure was not exercised");
        end
        if (flush_count == 0 || retire_count == 0) begin
            error_count++;
            $display("no flush or no retirement happened during the run");
        end
        $display("checks %0d errors %0d dispatches %0d retires %0d flushes %0d full cycles %0d",
                 check_total, error_count, dispatch_count, retire_count, flush_count,
                 full_cycles);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit()) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout, the run did not end within %0d cycles", cycle_count);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  rename_pkg::arch_idx_t dispatch_src1,
    input  rename_pkg::arch_idx_t dispatch_src2,
    input  rename_pkg::arch_idx_t dispatch_dest,
    input  logic                  complete_valid,
    input  rename_pkg::rob_idx_t  complete_tag,
    input  logic                  flush,
    output logic                  dispatch_ready,
    output rename_pkg::phys_idx_t renamed_src1,
    output rename_pkg::phys_idx_t renamed_src2,
    output rename_pkg::phys_idx_t renamed_dest,
    output rename_pkg::rob_idx_t  dispatch_tag,
    output logic                  retire_valid,
    output rename_pkg::arch_idx_t retire_dest,
    output rename_pkg::phys_idx_t retire_phys,
    output logic                  recovering
);
    import rename_pkg::*;

    rename_state_t state;
    logic      rename_allowed, walk_step;
    logic      rob_full, rob_empty, head_done;
    rob_idx_t  rob_head, rob_tail, rob_youngest;
    arch_idx_t head_dest, young_dest;
    phys_idx_t head_old, young_old, young_new;
    phys_idx_t dest_old_phys, fl_head_phys;
    logic      dispatch_en, retire_en, complete_en;

    ////////////////////
    // shared enables
    ////////////////////

    assign dispatch_en = rename_allowed && !rob_full && dispatch_valid;
    assign retire_en   = rename_allowed && head_done && !rob_empty;  // same gate as rename
    assign complete_en = complete_valid && (state == RENAME);       // dropped while walking

    rename_ctrl ctrl_i (
        .clock(clock), .reset(reset), .flush(flush), .rob_empty(rob_empty),
        .state(state), .rename_allowed(rename_allowed), .walk_step(walk_step)
    );

    map_table map_i (
        .clock(clock), .reset(reset),
        .src1(dispatch_src1), .src2(dispatch_src2), .dest(dispatch_dest),
        .rename_en(dispatch_en), .new_phys(fl_head_phys),
        .restore_en(walk_step), .restore_dest(young_dest), .restore_phys(young_old),
        .src1_phys(renamed_src1), .src2_phys(renamed_src2), .dest_old_phys(dest_old_phys)
    );

    free_list fl_i (
        .clock(clock), .reset(reset),
        .pop(dispatch_en), .push(retire_en), .push_phys(head_old),  // retiring old mapping
        .unpop(walk_step), .head_phys(fl_head_phys)
    );

    rob_pointers ptr_i (
        .clock(clock), .reset(reset),
        .alloc(dispatch_en), .retire(retire_en), .walk(walk_step),
        .head(rob_head), .tail(rob_tail), .youngest(rob_youngest),
        .full(rob_full), .empty(rob_empty)
    );

    rob_entries ent_i (
        .clock(clock), .reset(reset),
        .alloc(dispatch_en), .alloc_slot(rob_tail), .alloc_dest(dispatch_dest),
        .alloc_new(fl_head_phys), .alloc_old(dest_old_phys),
        .complete_valid(complete_en), .complete_slot(complete_tag),
        .head(rob_head), .youngest(rob_youngest),
        .head_done(head_done), .head_dest(head_dest), .head_old(head_old),
        .young_dest(young_dest), .young_old(young_old), .young_new(young_new)
    );

    assign dispatch_ready = rename_allowed && !rob_full;
    assign renamed_dest   = fl_head_phys;
    assign dispatch_tag   = rob_tail;
    assign retire_valid   = retire_en;
    assign retire_dest    = head_dest;
    assign retire_phys    = head_old;
    assign recovering     = (state == WALK);

    // unpop hands back exactly the register the youngest entry took
    walk_head_a: assert property (@(posedge clock) disable iff (reset)
        walk_step |=> fl_head_phys == $past(young_new));

endmodule

`default_nettype wire

// ==== rob/rob_entries.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rob_entries (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  alloc,
    input  rename_pkg::rob_idx_t  alloc_slot,
    input  rename_pkg::arch_idx_t alloc_dest,
    input  rename_pkg::phys_idx_t alloc_new,
    input  rename_pkg::phys_idx_t alloc_old,
    input  logic                  complete_valid,
    input  rename_pkg::rob_idx_t  complete_slot,
    input  rename_pkg::rob_idx_t  head,
    input  rename_pkg::rob_idx_t  youngest,
    output logic                  head_done,
    output rename_pkg::arch_idx_t head_dest,
    output rename_pkg::phys_idx_t head_old,
    output rename_pkg::arch_idx_t young_dest,
    output rename_pkg::phys_idx_t young_old,
    output rename_pkg::phys_idx_t young_new
);
    import rename_pkg::*;

    arch_idx_t dest_q [`ROB_DEPTH];
    phys_idx_t new_q  [`ROB_DEPTH];
    phys_idx_t old_q  [`ROB_DEPTH];  // mapping replaced by this entry
    logic [`ROB_DEPTH-1:0] done_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            done_q <= '0;
        end else begin
            if (alloc) done_q[alloc_slot] <= 1'b0;
            if (complete_valid) done_q[complete_slot] <= 1'b1;  // never the tail slot
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            dest_q[alloc_slot] <= alloc_dest;
            new_q[alloc_slot]  <= alloc_new;
            old_q[alloc_slot]  <= alloc_old;
        end
    end

    // retire side
    assign head_done  = done_q[head];
    assign head_dest  = dest_q[head];
    assign head_old   = old_q[head];
    // walk side
    assign young_dest = dest_q[youngest];
    assign young_old  = old_q[youngest];
    assign young_new  = new_q[youngest];

    no_double_done_a: assert property (@(posedge clock) disable iff (reset)
        complete_valid |-> !done_q[complete_slot]);

endmodule

`default_nettype wire

// ==== rob/rob_pointers.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rob_pointers (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 alloc,     // dispatch
    input  logic                 retire,    // oldest leaves
    input  logic                 walk,      // youngest undone
    output rename_pkg::rob_idx_t head,
    output rename_pkg::rob_idx_t tail,
    output rename_pkg::rob_idx_t youngest,
    output logic                 full,
    output logic                 empty
);
    import rename_pkg::*;

    rob_idx_t   head_q;
    rob_idx_t   tail_q;
    rob_count_t count_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc) tail_q <= tail_q + 1'b1;
            else if (walk) tail_q <= tail_q - 1'b1;  // back off youngest
            if (retire) head_q <= head_q + 1'b1;
            count_q <= count_q + rob_count_t'(alloc) - rob_count_t'(retire)
                       - rob_count_t'(walk);
        end
    end

    assign head     = head_q;
    assign tail     = tail_q;
    assign youngest = tail_q - 1'b1;  // only meaningful when not empty
    assign full     = (count_q == rob_count_t'(`ROB_DEPTH));
    assign empty    = (count_q == '0);

    no_alloc_full_a: assert property (@(posedge clock) disable iff (reset)
        alloc |-> !full);

endmodule

`default_nettype wire

// ==== source/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module free_list (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  pop,        // dispatch takes head
    input  logic                  push,       // retire returns old phys
    input  rename_pkg::phys_idx_t push_phys,
    input  logic                  unpop,      // walk step gives head back
    output rename_pkg::phys_idx_t head_phys
);
    import rename_pkg::*;

    phys_idx_t  slots_q [`ROB_DEPTH];
    rob_idx_t   head_q;
    rob_idx_t   tail_q;
    rob_count_t count_q;  // free registers held

    ////////////////////
    // slot storage
    ////////////////////

    // initial content is the spare registers in order
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                slots_q[i] <= phys_idx_t'(`ARCH_REGS + i);
            end
        end else if (push) begin
            slots_q[tail_q] <= push_phys;
        end
    end

    ////////////////////
    // pointers
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;  // one past slot 7, wrapped
            count_q <= rob_count_t'(`ROB_DEPTH);
        end else begin
            if (pop) head_q <= head_q + 1'b1;
            else if (unpop) head_q <= head_q - 1'b1;  // popped slot still intact
            if (push) tail_q <= tail_q + 1'b1;
            count_q <= count_q + rob_count_t'(push) + rob_count_t'(unpop)
                       - rob_count_t'(pop);
        end
    end

    assign head_phys = slots_q[head_q];

    no_pop_empty_a: assert property (@(posedge clock) disable iff (reset)
        pop |-> count_q != '0);

endmodule

`default_nettype wire

// ==== source/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module map_table (
    input  logic                  clock,
    input  logic                  reset,
    input  rename_pkg::arch_idx_t src1,
    input  rename_pkg::arch_idx_t src2,
    input  rename_pkg::arch_idx_t dest,
    input  logic                  rename_en,
    input  rename_pkg::phys_idx_t new_phys,
    input  logic                  restore_en,
    input  rename_pkg::arch_idx_t restore_dest,
    input  rename_pkg::phys_idx_t restore_phys,
    output rename_pkg::phys_idx_t src1_phys,
    output rename_pkg::phys_idx_t src2_phys,
    output rename_pkg::phys_idx_t dest_old_phys
);
    import rename_pkg::*;

    phys_idx_t map_q [`ARCH_REGS];  // arch -> phys

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= phys_idx_t'(i);  // identity at start
            end
        end else if (restore_en) begin
            map_q[restore_dest] <= restore_phys;  // undo one rename
        end else if (rename_en) begin
            map_q[dest] <= new_phys;
        end
    end

    // reads see table before this cycle's write
    assign src1_phys     = map_q[src1];
    assign src2_phys     = map_q[src2];
    assign dest_old_phys = map_q[dest];  // saved in rob for retire / walk

    // controller keeps rename and walk apart
    no_double_write_a: assert property (@(posedge clock) disable iff (reset)
        !(rename_en && restore_en));

endmodule

`default_nettype wire

// ==== source/rename_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_ctrl (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    rob_empty,
    output rename_pkg::rename_state_t state,
    output logic                    rename_allowed,  // also gates retire
    output logic                    walk_step
);
    import rename_pkg::*;

    rename_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            RENAME:  if (flush) state_next = WALK;
            WALK:    if (rob_empty) state_next = RENAME;  // last walk cycle
            default: state_next = RENAME;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= RENAME;
        end else begin
            state <= state_next;
        end
    end

    // rename / retire and walk are mutually exclusive by construction
    assign rename_allowed = (state == RENAME) && !flush;
    assign walk_step      = (state == WALK) && !rob_empty;  // one rob entry per cycle

    ////////////////////
    // checks
    ////////////////////

    // rob drains within depth cycles once walking
    walk_ends_a: assert property (@(posedge clock) disable iff (reset)
        $rose(state == WALK) |-> ##[0:`ROB_DEPTH] rob_empty);

endmodule

`default_nettype wire

// ==== common/rename_pkg.sv ====
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

    ////////////////////
    // index types
    ////////////////////

    typedef logic [$clog2(`ARCH_REGS)-1:0]   arch_idx_t;   // 3 bits
    typedef logic [$clog2(`PHYS_REGS)-1:0]   phys_idx_t;   // 4 bits
    typedef logic [$clog2(`ROB_DEPTH)-1:0]   rob_idx_t;    // 3 bits, wraps
    typedef logic [$clog2(`ROB_DEPTH+1)-1:0] rob_count_t;  // 0..8

    ////////////////////
    // controller state
    ////////////////////

    typedef enum logic {
        RENAME = 1'b0,  // normal dispatch and retire
        WALK   = 1'b1   // undoing rob entries youngest first
    } rename_state_t;

endpackage

`default_nettype wire

// ==== common/rename_defines.svh ====
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file size
`define ARCH_REGS 8

// physical register pool, arch plus rename spares
`define PHYS_REGS 16

// one rob slot per spare physical register
// so free list count == ROB_DEPTH - occupancy
`define ROB_DEPTH 8

`endif
